//--- fma_pkg.sv
// fma shared types and constants
package fma_pkg;

   typedef logic [31:0] float_t;
   typedef logic [7:0]  exp_t;
   typedef logic [23:0] man_t;
   typedef logic [47:0] prod_t;
   typedef logic [74:0] frame_t;
   typedef logic [75:0] wide_t;
   typedef logic [26:0] rman_t;
   typedef logic [6:0]  lz_t;

   localparam int EXP_BIAS = 127;

   // addend shifts past these switch to concatenate mode
   localparam int FAR_RIGHT_LIMIT = 47;
   localparam int FAR_LEFT_LIMIT  = 28;

   // frame msb sits 29 places above the product exponent
   localparam int NORM_OFFSET = 29;

   typedef struct packed {
      logic valid;
      man_t man_a;
      man_t man_b;
      man_t man_c;
      exp_t prod_exp;
      exp_t exp_c;
      exp_t shift;
      logic shift_right;
      logic sign_ab;
      logic eff_sub;
   } unpack_t;

   typedef struct packed {
      logic   valid;
      frame_t addend;
      logic   add_mode;
      logic   shift_right;
      exp_t   prod_exp;
      exp_t   exp_c;
      logic   sign_ab;
      logic   eff_sub;
   } align_t;

   typedef struct packed {
      logic  valid;
      wide_t mag;
      logic  sign;
      logic  add_mode;
      logic  shift_right;
      exp_t  prod_exp;
      exp_t  exp_c;
   } sum_t;

   typedef struct packed {
      logic  valid;
      rman_t rman;
      logic  sign;
      logic  add_mode;
      logic  shift_right;
      exp_t  prod_exp;
      exp_t  exp_c;
      // two's complement adjustment
      exp_t  exp_adj;
   } norm_t;

endpackage

//--- fma_unpack.sv
// operand unpack stage
module fma_unpack (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  fma_pkg::float_t  in_a,
   input  fma_pkg::float_t  in_b,
   input  fma_pkg::float_t  in_c,
   output fma_pkg::unpack_t stage1
);
   import fma_pkg::*;

   logic signed [9:0] exp_ab;
   logic signed [9:0] prod_exp_s;
   logic signed [9:0] diff;
   logic        [9:0] diff_mag;
   unpack_t           stage1_d;

   // subnormal inputs share the minimum exponent
   function automatic logic signed [9:0] true_exp(input exp_t e);
      if (e == '0) begin
         return -10'sd126;
      end
      return $signed({2'b00, e}) - 10'(EXP_BIAS);
   endfunction

   function automatic man_t hidden_man(input float_t f);
      return {|f[30:23], f[22:0]};
   endfunction

   always_comb begin
      exp_ab     = true_exp(in_a[30:23]) + true_exp(in_b[30:23]);
      prod_exp_s = exp_ab + 10'(EXP_BIAS);
      diff       = true_exp(in_c[30:23]) - exp_ab;
      diff_mag   = diff[9] ? unsigned'(-diff) : unsigned'(diff);

      stage1_d.valid    = in_valid;
      stage1_d.man_a    = hidden_man(in_a);
      stage1_d.man_b    = hidden_man(in_b);
      stage1_d.man_c    = hidden_man(in_c);
      stage1_d.prod_exp = prod_exp_s[9] ? '0 : prod_exp_s[7:0];
      stage1_d.exp_c    = in_c[30:23];
      // saturate, anything this far is concatenate mode
      stage1_d.shift       = (diff_mag > 10'd255) ? 8'hff : diff_mag[7:0];
      stage1_d.shift_right = diff[9];
      stage1_d.sign_ab     = in_a[31] ^ in_b[31];
      stage1_d.eff_sub     = in_a[31] ^ in_b[31] ^ in_c[31];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage1 <= '0;
      end else begin
         stage1 <= stage1_d;
      end
   end

endmodule

//--- fma_booth_mul.sv
// booth radix-4 mantissa multiplier
module fma_booth_mul (
   input  logic             clk,
   input  logic             rst_n,
   input  fma_pkg::unpack_t stage1,
   output fma_pkg::prod_t   product
);
   import fma_pkg::*;

   typedef logic [49:0] row_t;

   logic [26:0] mb_ext;
   row_t        pp [13];
   row_t        l1 [8];
   row_t        l2 [4];
   row_t        l3 [4];
   row_t        l4 [2];
   row_t        l5 [2];
   row_t        fin [2];
   row_t        sum_full;

   function automatic row_t booth_pp(input man_t a, input logic [2:0] code, input int pos);
      row_t one;
      row_t two;
      one = row_t'(a);
      two = row_t'(a) << 1;
      case (code)
         3'b001, 3'b010: return one << pos;
         3'b011:         return two << pos;
         3'b100:         return (~two + 1'b1) << pos;
         3'b101, 3'b110: return (~one + 1'b1) << pos;
         default:        return '0;
      endcase
   endfunction

   // 3:2 compressor, carry row on top
   function automatic logic [99:0] csa(input row_t x, input row_t y, input row_t z);
      row_t s;
      row_t c;
      s = x ^ y ^ z;
      c = ((x & y) | (y & z) | (x & z)) << 1;
      return {c, s};
   endfunction

   always_comb begin
      // two zero digits on top keep the multiplier unsigned
      mb_ext = {2'b00, stage1.man_b, 1'b0};
      for (int i = 0; i < 13; i++) begin
         pp[i] = booth_pp(stage1.man_a, mb_ext[2*i +: 3], 2 * i);
      end
   end

   assign {l1[1], l1[0]} = csa(pp[0], pp[1], pp[2]);
   assign {l1[3], l1[2]} = csa(pp[3], pp[4], pp[5]);
   assign {l1[5], l1[4]} = csa(pp[6], pp[7], pp[8]);
   assign {l1[7], l1[6]} = csa(pp[9], pp[10], pp[11]);

   assign {l2[1], l2[0]} = csa(l1[0], l1[1], l1[2]);
   assign {l2[3], l2[2]} = csa(l1[3], l1[4], l1[5]);

   assign {l3[1], l3[0]} = csa(l2[0], l2[1], l2[2]);
   assign {l3[3], l3[2]} = csa(l2[3], l1[6], l1[7]);

   assign {l4[1], l4[0]} = csa(l3[0], l3[1], l3[2]);
   assign {l5[1], l5[0]} = csa(l4[0], l4[1], l3[3]);

   // last partial product joins at the final compressor
   assign {fin[1], fin[0]} = csa(l5[0], l5[1], pp[12]);
   assign sum_full = fin[0] + fin[1];

   // hold the product between operations
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         product <= '0;
      end else if (stage1.valid) begin
         product <= sum_full[47:0];
      end
   end

endmodule

//--- fma_addend_align.sv
// addend alignment stage
module fma_addend_align (
   input  logic             clk,
   input  logic             rst_n,
   input  fma_pkg::unpack_t stage1,
   output fma_pkg::align_t  stage2
);
   import fma_pkg::*;

   frame_t ext_c;
   logic   far_right;
   logic   far_left;
   align_t stage2_d;

   always_comb begin
      // c lsb lines up with product bit 23 at equal exponents
      ext_c     = {28'b0, stage1.man_c, 23'b0};
      far_right = stage1.shift_right && (stage1.shift > exp_t'(FAR_RIGHT_LIMIT));
      far_left  = !stage1.shift_right && (stage1.shift > exp_t'(FAR_LEFT_LIMIT));

      if (stage1.shift_right) begin
         stage2_d.addend = ext_c >> stage1.shift;
      end else if (far_left) begin
         stage2_d.addend = {1'b0, stage1.man_c, 50'b0};
      end else begin
         stage2_d.addend = ext_c << stage1.shift;
      end

      stage2_d.valid       = stage1.valid;
      stage2_d.add_mode    = !(far_right || far_left);
      stage2_d.shift_right = stage1.shift_right;
      stage2_d.prod_exp    = stage1.prod_exp;
      stage2_d.exp_c       = stage1.exp_c;
      stage2_d.sign_ab     = stage1.sign_ab;
      stage2_d.eff_sub     = stage1.eff_sub;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage2 <= '0;
      end else begin
         stage2 <= stage2_d;
      end
   end

endmodule

//--- fma_add.sv
// signed 76-bit add stage
module fma_add (
   input  logic            clk,
   input  logic            rst_n,
   input  fma_pkg::prod_t  product,
   input  fma_pkg::align_t stage2,
   output fma_pkg::sum_t   stage3
);
   import fma_pkg::*;

   logic  far_left;
   wide_t prod_ext;
   wide_t addend_ext;
   wide_t sum;
   sum_t  stage3_d;

   always_comb begin
      far_left = !stage2.add_mode && !stage2.shift_right;
      // far-left product lies below the round position of c
      prod_ext = far_left ? '0 : {28'b0, product};
      // invert plus carry-in gives the negated addend
      addend_ext = stage2.eff_sub ? {1'b1, ~stage2.addend} : {1'b0, stage2.addend};
      sum        = prod_ext + addend_ext + wide_t'(stage2.eff_sub);

      stage3_d.valid       = stage2.valid;
      stage3_d.mag         = sum[75] ? -sum : sum;
      stage3_d.sign        = stage2.sign_ab ^ sum[75];
      stage3_d.add_mode    = stage2.add_mode;
      stage3_d.shift_right = stage2.shift_right;
      stage3_d.prod_exp    = stage2.prod_exp;
      stage3_d.exp_c       = stage2.exp_c;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage3 <= '0;
      end else begin
         stage3 <= stage3_d;
      end
   end

endmodule

//--- fma_normalize.sv
// leading-zero normalize stage
module fma_normalize (
   input  logic          clk,
   input  logic          rst_n,
   input  fma_pkg::sum_t stage3,
   output fma_pkg::norm_t stage4
);
   import fma_pkg::*;

   lz_t        lz;
   logic [8:0] cap;
   lz_t        applied;
   wide_t      shifted;
   norm_t      stage4_d;

   // priority encoder, highest set bit wins
   always_comb begin
      lz = lz_t'(76);
      for (int i = 0; i < 76; i++) begin
         if (stage3.mag[i]) begin
            lz = lz_t'(75 - i);
         end
      end
   end

   always_comb begin
      // keep the result exponent from going below zero
      cap     = {1'b0, stage3.prod_exp} + 9'(NORM_OFFSET);
      applied = ({2'b00, lz} > cap) ? cap[6:0] : lz;
      shifted = stage3.mag << applied;

      stage4_d.valid = stage3.valid;
      // everything under the round bit folds into sticky
      stage4_d.rman        = {shifted[75:50], |shifted[49:0]};
      stage4_d.sign        = stage3.sign;
      stage4_d.add_mode    = stage3.add_mode;
      stage4_d.shift_right = stage3.shift_right;
      stage4_d.prod_exp    = stage3.prod_exp;
      stage4_d.exp_c       = stage3.exp_c;
      stage4_d.exp_adj     = exp_t'(NORM_OFFSET) - {1'b0, applied};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage4 <= '0;
      end else begin
         stage4 <= stage4_d;
      end
   end

endmodule

//--- fma_round.sv
// round to nearest even stage
module fma_round (
   input  logic            clk,
   input  logic            rst_n,
   input  fma_pkg::norm_t  stage4,
   output logic            out_valid,
   output fma_pkg::float_t out_result
);
   import fma_pkg::*;

   logic        far_left;
   logic        guard;
   logic        round_bit;
   logic        sticky;
   man_t        man;
   logic        round_up;
   logic [24:0] man_inc;
   exp_t        exp_final;
   float_t      result_d;

   always_comb begin
      far_left = !stage4.add_mode && !stage4.shift_right;
      man      = stage4.rman[26:3];
      // far-left result is c itself, nothing to round
      guard     = far_left ? 1'b0 : stage4.rman[2];
      round_bit = far_left ? 1'b0 : stage4.rman[1];
      sticky    = far_left ? 1'b0 : stage4.rman[0];

      // ties go to the even mantissa
      round_up = guard && (round_bit || sticky || man[0]);
      man_inc  = {1'b0, man} + 25'(round_up);

      // carry out leaves an all-zero mantissa one binade up
      if (far_left) begin
         exp_final = stage4.exp_c + exp_t'(man_inc[24]);
      end else begin
         exp_final = stage4.prod_exp + stage4.exp_adj + exp_t'(man_inc[24]);
      end

      result_d = {stage4.sign, exp_final, man_inc[22:0]};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         out_result <= '0;
      end else begin
         out_valid  <= stage4.valid;
         out_result <= result_d;
      end
   end

endmodule

//--- fma_top.sv
// pipelined fused multiply-add
module fma_top (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_valid,
   input  fma_pkg::float_t in_a,
   input  fma_pkg::float_t in_b,
   input  fma_pkg::float_t in_c,
   output logic            out_valid,
   output fma_pkg::float_t out_result
);
   import fma_pkg::*;

   unpack_t stage1;
   prod_t   product;
   align_t  stage2;
   sum_t    stage3;
   norm_t   stage4;

   fma_unpack u_unpack (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_a     (in_a),
      .in_b     (in_b),
      .in_c     (in_c),
      .stage1   (stage1)
   );

   // stage 2 runs the multiplier and the alignment side by side
   fma_booth_mul u_mul (
      .clk     (clk),
      .rst_n   (rst_n),
      .stage1  (stage1),
      .product (product)
   );

   fma_addend_align u_align (
      .clk    (clk),
      .rst_n  (rst_n),
      .stage1 (stage1),
      .stage2 (stage2)
   );

   fma_add u_add (
      .clk     (clk),
      .rst_n   (rst_n),
      .product (product),
      .stage2  (stage2),
      .stage3  (stage3)
   );

   fma_normalize u_norm (
      .clk    (clk),
      .rst_n  (rst_n),
      .stage3 (stage3),
      .stage4 (stage4)
   );

   fma_round u_round (
      .clk        (clk),
      .rst_n      (rst_n),
      .stage4     (stage4),
      .out_valid  (out_valid),
      .out_result (out_result)
   );

endmodule

//--- fma_properties.sv
// fma result and latency checks
module fma_properties (
   input logic            clk,
   input logic            rst_n,
   input logic            in_valid,
   input fma_pkg::float_t in_a,
   input fma_pkg::float_t in_b,
   input fma_pkg::float_t in_c,
   input logic            out_valid,
   input fma_pkg::float_t out_result
);
   timeunit 1ns;
   timeprecision 1ps;
   import fma_pkg::*;

   float_t expect_pipe [5];
   logic   issued;
   int     idle_fails   = 0;
   int     valid_fails  = 0;
   int     result_fails = 0;

   // operands are integer valued, so the scaling is exact
   function automatic longint to_int(input float_t f);
      longint mag;
      int     e;
      e = int'(f[30:23]);
      if (e == 0) begin
         return 0;
      end
      mag = longint'({1'b1, f[22:0]});
      if (e >= 150) begin
         mag = mag << (e - 150);
      end else begin
         mag = mag >> (150 - e);
      end
      return f[31] ? -mag : mag;
   endfunction

   // nearest even on the exact integer result
   function automatic float_t round_to_float(input longint r);
      longint mag;
      longint keep;
      longint rem;
      longint half;
      int     p;
      int     sh;
      mag = (r < 0) ? -r : r;
      p   = 0;
      for (int i = 0; i < 63; i++) begin
         if (mag[i]) begin
            p = i;
         end
      end
      if (p <= 23) begin
         keep = mag << (23 - p);
      end else begin
         sh   = p - 23;
         keep = mag >> sh;
         rem  = mag & ((longint'(1) << sh) - 1);
         half = longint'(1) << (sh - 1);
         if (rem > half || (rem == half && keep[0])) begin
            keep = keep + 1;
         end
         // mantissa overflow moves up one binade
         if (keep[24]) begin
            keep = keep >> 1;
            p    = p + 1;
         end
      end
      return {r < 0, 8'(EXP_BIAS + p), keep[22:0]};
   endfunction

   // expected results follow the five pipeline stages
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         expect_pipe <= '{default: '0};
         issued      <= 1'b0;
      end else begin
         expect_pipe[0] <= round_to_float(to_int(in_a) * to_int(in_b) + to_int(in_c));
         for (int i = 1; i < 5; i++) begin
            expect_pipe[i] <= expect_pipe[i-1];
         end
         issued <= issued | in_valid;
      end
   end

   a_idle: assert property (@(posedge clk) disable iff (!rst_n) !issued |-> !out_valid)
      else begin
         idle_fails++;
         $error("out_valid went high at %0t before any operation was issued", $time);
      end

   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
         out_valid == $past(in_valid, 5))
      else begin
         valid_fails++;
         $error("Mismatch at %0t: out_valid %b does not follow in_valid five cycles earlier",
                $time, $sampled(out_valid));
      end

   a_result: assert property (@(posedge clk) disable iff (!rst_n)
         out_valid |-> out_result == expect_pipe[4])
      else begin
         result_fails++;
         $error("Mismatch at %0t: result %h, expected %h", $time,
                $sampled(out_result), $sampled(expect_pipe[4]));
      end

endmodule

//--- fma_tb.sv
// fma pipeline testbench
module fma_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import fma_pkg::*;

   logic   clk = 1'b0;
   logic   rst_n;
   logic   in_valid;
   float_t in_a;
   float_t in_b;
   float_t in_c;
   logic   out_valid;
   float_t out_result;

   int issued       = 0;
   int received     = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int timeouts     = 0;

   fma_top u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_a       (in_a),
      .in_b       (in_b),
      .in_c       (in_c),
      .out_valid  (out_valid),
      .out_result (out_result)
   );

   bind fma_top fma_properties u_props (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_a       (in_a),
      .in_b       (in_b),
      .in_c       (in_c),
      .out_valid  (out_valid),
      .out_result (out_result)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      if (rst_n && out_valid) begin
         received <= received + 1;
      end
   end

   // integers here fit in 24 significant bits
   function automatic float_t to_float(input longint v);
      longint mag;
      longint mant;
      int     p;
      if (v == 0) begin
         return '0;
      end
      mag = (v < 0) ? -v : v;
      p   = 0;
      for (int i = 0; i < 63; i++) begin
         if (mag[i]) begin
            p = i;
         end
      end
      mant = (p > 23) ? (mag >> (p - 23)) : (mag << (23 - p));
      return {v < 0, 8'(EXP_BIAS + p), mant[22:0]};
   endfunction

   function automatic int assert_fails();
      return u_dut.u_props.idle_fails + u_dut.u_props.valid_fails +
             u_dut.u_props.result_fails;
   endfunction

   task automatic issue(input longint a, input longint b, input longint c);
      @(negedge clk);
      in_valid = 1'b1;
      in_a     = to_float(a);
      in_b     = to_float(b);
      in_c     = to_float(c);
      issued++;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         in_valid = 1'b0;
      end
   endtask

   // drain the pipeline, then report the test
   task automatic finish_test(input string name, input int fails_before);
      int cycles;
      cycles = 0;
      @(negedge clk);
      in_valid = 1'b0;
      while (received != issued && cycles < 40) begin
         @(negedge clk);
         cycles++;
      end
      tests_run++;
      if (received != issued) begin
         timeouts++;
         tests_failed++;
         $display("test %0d %s: timed out with %0d of %0d results back", tests_run, name,
                  received, issued);
      end else if (assert_fails() != fails_before) begin
         tests_failed++;
         $display("test %0d %s: %0d checks failed", tests_run, name,
                  assert_fails() - fails_before);
      end else begin
         $display("test %0d %s: ok", tests_run, name);
      end
   endtask

   task automatic random_ops(input int count);
      longint a;
      longint b;
      longint c;
      for (int i = 0; i < count; i++) begin
         a = longint'($urandom % 32'hfffff) + 1;
         b = longint'($urandom % 32'h7ffff) + 1;
         c = longint'($urandom % 32'h100_0000) << ($urandom % 16);
         if ($urandom % 2 == 1) begin
            a = -a;
         end
         if ($urandom % 2 == 1) begin
            c = -c;
         end
         if (a * b + c == 0) begin
            c = 0;
         end
         issue(a, b, c);
      end
   endtask

   initial begin
      int base;
      void'($urandom(32'h7ac1_a491));
      rst_n    = 1'b0;
      in_valid = 1'b0;
      in_a     = '0;
      in_b     = '0;
      in_c     = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      base = assert_fails();
      idle(10);
      finish_test("idle after reset", base);

      base = assert_fails();
      issue(3, 5, 7);
      idle(2);
      issue(2, 3, 1000);
      issue(6, 7, 8);
      idle(1);
      issue(-9, 4, 5);
      idle(3);
      issue(11, 13, -2);
      finish_test("valid latency with gaps", base);

      base = assert_fails();
      issue(3, 5, 7);
      issue(2, 3, 1000);
      issue(-4, 6, -10);
      issue(100, 200, 1);
      issue(1, 1, 1);
      issue(7, 7, longint'(1) << 20);
      finish_test("same-sign add", base);

      base = assert_fails();
      issue(1000, 1000, -999999);
      issue(4097, 4095, -16777214);
      issue(7, 9, -100);
      issue(123, 45, -5536);
      issue(-300, 300, 90001);
      issue(65535, 65537, -(longint'(1) << 32));
      finish_test("cancellation", base);

      base = assert_fails();
      issue(4097, 4097, 0);
      issue(4097, 4097, -1);
      issue(8193, 8191, 0);
      issue(16777215, 3, 0);
      issue(1048575, 524287, 1);
      issue(3, 5, longint'(1) << 39);
      issue(3, 5, -(longint'(1) << 39));
      finish_test("rounding and far addend", base);

      base = assert_fails();
      random_ops(50);
      finish_test("random back-to-back", base);

      $display("tests %0d, failed %0d, timeouts %0d, assertion failures %0d",
               tests_run, tests_failed, timeouts, assert_fails());
      if (tests_failed == 0 && assert_fails() == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- src.f
fma_pkg.sv
fma_unpack.sv
fma_booth_mul.sv
fma_addend_align.sv
fma_add.sv
fma_normalize.sv
fma_round.sv
fma_top.sv
fma_properties.sv
fma_tb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
LINT      := --lint-only --timing --assert
TOP       := fma_tb
FILELIST  := src.f
BUILD     := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
